//--- design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [15:0] mem_addr_t;

    typedef enum logic [6:0] {
        OP_ADD   = 7'h01,
        OP_SUB   = 7'h02,
        OP_AND   = 7'h03,
        OP_OR    = 7'h04,
        OP_XOR   = 7'h05,
        OP_ADDI  = 7'h06,
        OP_CMPLT = 7'h07,
        OP_LOAD  = 7'h08,
        OP_STORE = 7'h09,
        OP_BRF   = 7'h0a,   // Taken when flag of rs_a is set
        OP_JMP   = 7'h0b,
        OP_HALT  = 7'h0c
    } opcode_e;

    // Opcode sits in the low bits of the word
    typedef struct packed {
        logic [15:0] imm;
        reg_idx_t    rs_b;
        reg_idx_t    rs_a;
        reg_idx_t    rd;
        opcode_e     opcode;
    } instr_t;

    typedef struct packed {
        logic      re;
        logic      we;
        mem_addr_t addr;
        word_t     wdata;
    } mem_req_t;

    typedef struct packed {
        word_t result;
        logic  flag;
    } alu_out_t;

    typedef enum logic [1:0] {
        EXECUTE,
        MEM_WAIT,
        HALTED
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                    clock,
    input  wire                    rst,
    input  wire cpu_pkg::reg_idx_t rd_idx_a,
    input  wire cpu_pkg::reg_idx_t rd_idx_b,
    output cpu_pkg::word_t         rd_data_a,
    output cpu_pkg::word_t         rd_data_b,
    input  wire cpu_pkg::reg_idx_t flag_idx,
    output logic                   flag_out,
    input  wire                    wr_en,
    input  wire cpu_pkg::reg_idx_t wr_idx,
    input  wire cpu_pkg::alu_out_t wr_data
);
    import cpu_pkg::*;

    word_t      regs [0:7];
    logic [7:0] flags;

    // Combinational reads
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];
    assign flag_out  = flags[flag_idx];

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < 8; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else if (wr_en)
        begin
            regs[wr_idx]  <= wr_data.result;
            flags[wr_idx] <= wr_data.flag;   // Flag follows its register
        end
    end

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire cpu_pkg::opcode_e op,
    input  wire cpu_pkg::word_t   a,
    input  wire cpu_pkg::word_t   b,
    input  wire [15:0]            imm,
    output cpu_pkg::alu_out_t     result
);
    import cpu_pkg::*;

    word_t simm;
    logic  lt;

    assign simm = {{16{imm[15]}}, imm};
    assign lt   = $signed(a) < $signed(b);

    always_comb
    begin
        case (op)
            OP_ADD:
                result.result = a + b;
            OP_SUB:
                result.result = a - b;
            OP_AND:
                result.result = a & b;
            OP_OR:
                result.result = a | b;
            OP_XOR:
                result.result = a ^ b;
            OP_ADDI, OP_LOAD, OP_STORE:
                result.result = a + simm;   // Also the data address
            OP_CMPLT:
                result.result = {31'b0, lt};
            default:
                result.result = '0;
        endcase

        // Compare result replaces the zero test
        if (op == OP_CMPLT)
        begin
            result.flag = lt;
        end
        else
        begin
            result.flag = (result.result == '0);
        end
    end

endmodule

`default_nettype wire

//--- design/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter cpu_pkg::mem_addr_t RESET_PC = '0
) (
    input  wire                     clock,
    input  wire                     rst,
    output logic                    fetch_req,
    output cpu_pkg::mem_addr_t      fetch_addr,
    input  wire                     fetch_grant,
    input  wire                     fetch_rvalid,
    input  wire cpu_pkg::word_t     fetch_rdata,
    output cpu_pkg::instr_t         instr,
    output logic                    instr_valid,
    input  wire                     instr_take,
    input  wire                     redirect,
    input  wire cpu_pkg::mem_addr_t redirect_pc
);
    import cpu_pkg::*;

    mem_addr_t pc;
    instr_t    instr_buf;
    logic      buf_valid;
    logic      in_flight;
    logic      stale;       // Return still due from the old path

    assign fetch_req   = ~rst & ~buf_valid & ~in_flight;   // Quiet while in reset
    assign fetch_addr  = pc;
    assign instr       = instr_buf;
    assign instr_valid = buf_valid;

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            pc        <= RESET_PC;
            buf_valid <= 1'b0;
            in_flight <= 1'b0;
            stale     <= 1'b0;
        end
        else
        begin
            in_flight <= fetch_grant | (in_flight & ~fetch_rvalid);
            if (redirect)
            begin
                pc        <= redirect_pc;
                buf_valid <= 1'b0;
                stale     <= fetch_grant | (in_flight & ~fetch_rvalid);
            end
            else
            begin
                if (fetch_grant)
                    pc <= pc + 1'b1;
                if (instr_take)
                    buf_valid <= 1'b0;
                if (fetch_rvalid)
                begin
                    if (stale)
                        stale <= 1'b0;   // Drop it
                    else
                        buf_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (fetch_rvalid && !stale && !redirect)
            instr_buf <= fetch_rdata;
    end

    a_rvalid_in_flight: assert property (@(posedge clock) disable iff (rst)
        fetch_rvalid |-> in_flight);

endmodule

`default_nettype wire

//--- design/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire                     clock,
    input  wire                     rst,
    input  wire                     fetch_req,
    input  wire cpu_pkg::mem_addr_t fetch_addr,
    output logic                    fetch_grant,
    input  wire cpu_pkg::mem_req_t  data_req,
    output logic                    data_grant,
    output logic                    fetch_rvalid,
    output logic                    data_rvalid,
    output cpu_pkg::word_t          rdata,
    output cpu_pkg::mem_req_t       mem_req,
    input  wire cpu_pkg::word_t     mem_rdata
);
    import cpu_pkg::*;

    logic data_active;
    logic rd_pending;
    logic rd_is_data;    // Owner of the read in flight

    // Data port first
    assign data_active = data_req.re | data_req.we;
    assign data_grant  = data_active;
    assign fetch_grant = fetch_req & ~data_active;

    always_comb
    begin
        if (data_active)
        begin
            mem_req = data_req;
        end
        else
        begin
            mem_req.re    = fetch_req;
            mem_req.we    = 1'b0;
            mem_req.addr  = fetch_addr;
            mem_req.wdata = '0;
        end
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            rd_pending <= 1'b0;
            rd_is_data <= 1'b0;
        end
        else
        begin
            rd_pending <= mem_req.re;
            rd_is_data <= data_req.re;
        end
    end

    assign fetch_rvalid = rd_pending & ~rd_is_data;
    assign data_rvalid  = rd_pending & rd_is_data;
    assign rdata        = mem_rdata;   // Same word, qualified per port

    a_one_grant: assert property (@(posedge clock) disable iff (rst)
        !(fetch_grant && data_grant));

    a_no_rw: assert property (@(posedge clock) disable iff (rst)
        !(mem_req.re && mem_req.we));

endmodule

`default_nettype wire

//--- design/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
    input  wire                    clock,
    input  wire                    rst,
    input  wire cpu_pkg::instr_t   instr,
    input  wire                    instr_valid,
    output logic                   instr_take,
    output logic                   redirect,
    output cpu_pkg::mem_addr_t     redirect_pc,
    output cpu_pkg::reg_idx_t      rd_idx_a,
    output cpu_pkg::reg_idx_t      rd_idx_b,
    input  wire cpu_pkg::word_t    rd_data_a,
    input  wire cpu_pkg::word_t    rd_data_b,
    output cpu_pkg::reg_idx_t      flag_idx,
    input  wire                    flag_out,
    output logic                   wr_en,
    output cpu_pkg::reg_idx_t      wr_idx,
    output cpu_pkg::alu_out_t      wr_data,
    output cpu_pkg::opcode_e       alu_op,
    output cpu_pkg::word_t         alu_a,
    output cpu_pkg::word_t         alu_b,
    output logic [15:0]            alu_imm,
    input  wire cpu_pkg::alu_out_t alu_result,
    output cpu_pkg::mem_req_t      data_req,
    input  wire                    data_grant,
    input  wire                    data_rvalid,
    input  wire cpu_pkg::word_t    rdata,
    output logic                   halted
);
    import cpu_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;

    assign rd_idx_a    = instr.rs_a;
    assign rd_idx_b    = instr.rs_b;
    assign flag_idx    = instr.rs_a;
    assign wr_idx      = instr.rd;
    assign alu_op      = instr.opcode;
    assign alu_a       = rd_data_a;
    assign alu_b       = rd_data_b;
    assign alu_imm     = instr.imm;
    assign redirect_pc = instr.imm;   // Absolute target
    assign halted      = (state == HALTED);

    always_comb
    begin
        state_next     = state;
        instr_take     = 1'b0;
        redirect       = 1'b0;
        wr_en          = 1'b0;
        wr_data        = alu_result;
        data_req.re    = 1'b0;
        data_req.we    = 1'b0;
        data_req.addr  = alu_result.result[15:0];
        data_req.wdata = rd_data_b;
        case (state)
            EXECUTE:
            begin
                if (instr_valid)
                begin
                    case (instr.opcode)
                        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_CMPLT:
                        begin
                            wr_en      = 1'b1;
                            instr_take = 1'b1;
                        end
                        OP_LOAD:
                        begin
                            data_req.re = 1'b1;
                            if (data_grant)
                                state_next = MEM_WAIT;
                        end
                        OP_STORE:
                        begin
                            data_req.we = 1'b1;
                            instr_take  = data_grant;   // Retires on grant
                        end
                        OP_BRF:
                        begin
                            redirect   = flag_out;
                            instr_take = 1'b1;
                        end
                        OP_JMP:
                        begin
                            redirect   = 1'b1;
                            instr_take = 1'b1;
                        end
                        OP_HALT:
                        begin
                            instr_take = 1'b1;
                            state_next = HALTED;
                        end
                        default:
                            instr_take = 1'b1;   // Unknown opcode, no effect
                    endcase
                end
            end
            MEM_WAIT:
            begin
                // Load stays in the buffer until its data returns
                wr_data.result = rdata;
                wr_data.flag   = (rdata == '0);
                if (data_rvalid)
                begin
                    wr_en      = 1'b1;
                    instr_take = 1'b1;
                    state_next = EXECUTE;
                end
            end
            HALTED:
                state_next = HALTED;
            default:
                state_next = EXECUTE;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (rst)
            state <= EXECUTE;
        else
            state <= state_next;
    end

    a_take_valid: assert property (@(posedge clock) disable iff (rst)
        instr_take |-> instr_valid);

    a_load_return: assert property (@(posedge clock) disable iff (rst)
        data_req.re && data_grant |=> data_rvalid);

endmodule

`default_nettype wire

//--- design/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter cpu_pkg::mem_addr_t RESET_PC = '0
) (
    input  wire                  clock,
    input  wire                  rst,
    output cpu_pkg::mem_req_t    mem_req,
    input  wire cpu_pkg::word_t  mem_rdata,
    output logic                 halted
);
    import cpu_pkg::*;

    logic      fetch_req;
    mem_addr_t fetch_addr;
    logic      fetch_grant;
    logic      fetch_rvalid;
    word_t     rdata;
    instr_t    instr;
    logic      instr_valid;
    logic      instr_take;
    logic      redirect;
    mem_addr_t redirect_pc;
    mem_req_t  data_req;
    logic      data_grant;
    logic      data_rvalid;
    reg_idx_t  rd_idx_a;
    reg_idx_t  rd_idx_b;
    word_t     rd_data_a;
    word_t     rd_data_b;
    reg_idx_t  flag_idx;
    logic      flag_out;
    logic      wr_en;
    reg_idx_t  wr_idx;
    alu_out_t  wr_data;
    opcode_e   alu_op;
    word_t     alu_a;
    word_t     alu_b;
    logic [15:0] alu_imm;
    alu_out_t  alu_result;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) fetch_i (
        .clock        (clock),
        .rst          (rst),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_grant  (fetch_grant),
        .fetch_rvalid (fetch_rvalid),
        .fetch_rdata  (rdata),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .instr_take   (instr_take),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    mem_arbiter arbiter_i (
        .clock        (clock),
        .rst          (rst),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_grant  (fetch_grant),
        .data_req     (data_req),
        .data_grant   (data_grant),
        .fetch_rvalid (fetch_rvalid),
        .data_rvalid  (data_rvalid),
        .rdata        (rdata),
        .mem_req      (mem_req),
        .mem_rdata    (mem_rdata)
    );

    cpu_control control_i (
        .clock       (clock),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_take  (instr_take),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .rd_idx_a    (rd_idx_a),
        .rd_idx_b    (rd_idx_b),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .flag_idx    (flag_idx),
        .flag_out    (flag_out),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .alu_op      (alu_op),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_imm     (alu_imm),
        .alu_result  (alu_result),
        .data_req    (data_req),
        .data_grant  (data_grant),
        .data_rvalid (data_rvalid),
        .rdata       (rdata),
        .halted      (halted)
    );

    reg_file regs_i (
        .clock     (clock),
        .rst       (rst),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .flag_idx  (flag_idx),
        .flag_out  (flag_out),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data)
    );

    alu alu_i (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .imm    (alu_imm),
        .result (alu_result)
    );

endmodule

`default_nettype wire

//--- bench/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// One instruction word from its fields
function automatic word_t encode(
    input opcode_e     op,
    input reg_idx_t    rd,
    input reg_idx_t    ra,
    input reg_idx_t    rb,
    input logic [15:0] imm
);
    instr_t ins;
    ins.imm    = imm;
    ins.rs_b   = rb;
    ins.rs_a   = ra;
    ins.rd     = rd;
    ins.opcode = op;
    return word_t'(ins);
endfunction

// Interprets model_mem from RESET_PC until HALT, queueing every store
task automatic run_model(output int steps, output logic reached_halt);
    word_t      r [0:7];
    logic [7:0] f;
    mem_addr_t  pc;
    mem_addr_t  ea;
    instr_t     ins;
    word_t      a;
    word_t      b;
    word_t      simm;
    word_t      res;
    logic       lt;
    int         i;
    for (i = 0; i < 8; i++)
        r[i] = '0;
    f            = '0;
    pc           = RESET_PC;
    steps        = 0;
    reached_halt = 1'b0;
    while (!reached_halt && steps < MODEL_STEP_LIMIT)
    begin
        ins  = instr_t'(model_mem[pc]);
        a    = r[ins.rs_a];
        b    = r[ins.rs_b];
        simm = {{16{ins.imm[15]}}, ins.imm};
        ea   = mem_addr_t'(a + simm);
        lt   = $signed(a) < $signed(b);
        pc   = pc + 16'd1;
        steps++;
        case (ins.opcode)
            OP_ADD:   res = a + b;
            OP_SUB:   res = a - b;
            OP_AND:   res = a & b;
            OP_OR:    res = a | b;
            OP_XOR:   res = a ^ b;
            OP_ADDI:  res = a + simm;
            OP_CMPLT: res = {31'b0, lt};
            OP_LOAD:  res = model_mem[ea];
            default:  res = '0;
        endcase
        case (ins.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_CMPLT, OP_LOAD:
            begin
                r[ins.rd] = res;
                f[ins.rd] = (ins.opcode == OP_CMPLT) ? lt : (res == '0);
            end
            OP_STORE:
            begin
                model_mem[ea] = b;
                exp_addr.push_back(ea);
                exp_data.push_back(b);
            end
            OP_BRF:
                if (f[ins.rs_a])
                    pc = ins.imm;
            OP_JMP:
                pc = ins.imm;
            OP_HALT:
                reached_halt = 1'b1;
            default:
                ;   // No effect
        endcase
    end
endtask

`endif

//--- bench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam mem_addr_t RESET_PC         = 16'h0000;
    localparam int        RESET_CYCLES     = 16;
    localparam int        MODEL_STEP_LIMIT = 4096;
    localparam int        SEED             = 32'h347d5bca;

    logic     clock;
    logic     rst;
    mem_req_t mem_req;
    word_t    mem_rdata;
    logic     halted;

    word_t     mem       [0:65535];
    word_t     model_mem [0:65535];
    mem_addr_t exp_addr  [$];
    word_t     exp_data  [$];
    mem_req_t  req_s;   // Request as seen mid-cycle

    int    errors;
    int    errors_at_start;
    int    tests;
    int    failed_tests;
    int    cycle;
    int    watch_start;
    int    watch_limit;
    logic  watch_on;
    int    stores_seen;
    int    prog_len;
    int    model_steps;
    string cur_name;

    `include "isa_model.svh"

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) dut_i (
        .clock     (clock),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Memory answers one cycle after the request and writes land at the accepting edge
    always
    begin
        @(negedge clock);
        req_s = mem_req;
        if (req_s.re && req_s.we)
        begin
            $display("re and we both high at cycle %0d", cycle);
            errors++;
        end
        @(posedge clock);
        #1;
        if (req_s.we)
        begin
            check_store(req_s.addr, req_s.wdata);
            mem[req_s.addr] = req_s.wdata;
        end
        if (req_s.re)
            mem_rdata = mem[req_s.addr];
    end

    always @(posedge clock)
    begin
        cycle <= cycle + 1;
        if (watch_on && (cycle - watch_start) > watch_limit)
        begin
            $display("timeout in %s: halted not seen within %0d cycles", cur_name, watch_limit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_store(input mem_addr_t addr, input word_t data);
        mem_addr_t ea;
        word_t     ed;
        if (exp_addr.size() == 0)
        begin
            $display("unexpected store of %h to address %h", data, addr);
            errors++;
        end
        else
        begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            stores_seen++;
            if (addr !== ea)
            begin
                $display("mismatch mem_req.addr: got %h expected %h", addr, ea);
                errors++;
            end
            if (data !== ed)
            begin
                $display("mismatch mem_req.wdata: got %h expected %h", data, ed);
                errors++;
            end
        end
    endtask

    function automatic word_t fill_word(input int a);
        return {16'(a) ^ 16'hc3a5, ~16'(a)};
    endfunction

    function automatic reg_idx_t pick_reg(input int lo, input int hi);
        return reg_idx_t'(lo + int'($urandom % (hi - lo + 1)));
    endfunction

    // Signed value in -span/2 .. span/2-1
    function automatic logic [15:0] small_imm(input int span);
        int v;
        v = int'($urandom % span) - span / 2;
        return v[15:0];
    endfunction

    function automatic opcode_e random_alu_op();
        case ($urandom % 6)
            0:       return OP_ADD;
            1:       return OP_SUB;
            2:       return OP_AND;
            3:       return OP_OR;
            4:       return OP_XOR;
            default: return OP_ADDI;
        endcase
    endfunction

    task automatic emit(input word_t w);
        mem[prog_len] = w;
        prog_len++;
    endtask

    // Holds the DUT in reset while the memory is refilled
    task automatic begin_test(input string name);
        int a;
        cur_name        = name;
        errors_at_start = errors;
        stores_seen     = 0;
        prog_len        = 0;
        exp_addr.delete();
        exp_data.delete();
        @(posedge clock);
        #1;
        rst = 1'b1;
        for (a = 0; a < 65536; a++)
            mem[a] = fill_word(a);
    endtask

    task automatic prepare_model();
        logic done;
        model_mem = mem;
        run_model(model_steps, done);
        if (!done)
        begin
            $display("model did not reach HALT in %s", cur_name);
            errors++;
        end
    endtask

    task automatic release_reset();
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        rst         = 1'b0;
        watch_limit = 8 * model_steps + 100;
        watch_start = cycle;
        watch_on    = 1'b1;
    endtask

    task automatic wait_halted();
        @(negedge clock);
        while (halted !== 1'b1)
            @(negedge clock);
        watch_on = 1'b0;
    endtask

    task automatic compare_memory();
        int a;
        int bad;
        bad = 0;
        for (a = 0; a < 65536; a++)
        begin
            if (mem[a] !== model_mem[a])
            begin
                if (bad < 4)
                    $display("mismatch mem[%h]: got %h expected %h", a[15:0], mem[a],
                             model_mem[a]);
                bad++;
            end
        end
        errors += bad;
    endtask

    task automatic finish_test();
        if (exp_addr.size() != 0)
        begin
            $display("%0d expected stores never appeared on the bus", exp_addr.size());
            errors++;
        end
        compare_memory();
        tests++;
        if (errors != errors_at_start)
            failed_tests++;
        $display("%s: %s, %0d instructions, %0d stores, %0d errors", cur_name,
                 (errors == errors_at_start) ? "ok" : "FAILED", model_steps, stores_seen,
                 errors - errors_at_start);
    endtask

    task automatic run_program();
        emit(encode(OP_HALT, 3'd0, 3'd0, 3'd0, 16'd0));
        prepare_model();
        release_reset();
        wait_halted();
        finish_test();
    endtask

    task automatic check_idle(input string when);
        if (mem_req.we !== 1'b0)
        begin
            $display("mismatch mem_req.we %s: got %h expected 0", when, mem_req.we);
            errors++;
        end
        if (dut_i.data_req.re !== 1'b0 || dut_i.data_req.we !== 1'b0)
        begin
            $display("mismatch data_req re/we %s: got %h/%h expected 0/0", when,
                     dut_i.data_req.re, dut_i.data_req.we);
            errors++;
        end
        if (halted !== 1'b0)
        begin
            $display("mismatch halted %s: got %h expected 0", when, halted);
            errors++;
        end
    endtask

    task automatic verify_reset_state();
        begin_test("reset_state");
        emit(encode(OP_HALT, 3'd0, 3'd0, 3'd0, 16'd0));
        prepare_model();
        @(negedge clock);
        check_idle("during reset");
        if (mem_req.re !== 1'b0)
        begin
            $display("mismatch mem_req.re during reset: got %h expected 0", mem_req.re);
            errors++;
        end
        release_reset();
        @(negedge clock);
        check_idle("after reset");
        while (mem_req.re !== 1'b1)
            @(negedge clock);
        if (mem_req.addr !== RESET_PC)
        begin
            $display("mismatch mem_req.addr: got %h expected %h", mem_req.addr, RESET_PC);
            errors++;
        end
        wait_halted();
        finish_test();
    endtask

    // r0 is never written and serves as a zero base
    task automatic alu_mix_program();
        int i;
        begin_test("alu_program");
        for (i = 1; i < 8; i++)
            emit(encode(OP_ADDI, reg_idx_t'(i), 3'd0, 3'd0, 16'($urandom)));
        for (i = 0; i < 40; i++)
            emit(encode(random_alu_op(), pick_reg(1, 7), pick_reg(0, 7), pick_reg(0, 7),
                        16'($urandom)));
        for (i = 0; i < 8; i++)
            emit(encode(OP_STORE, 3'd0, 3'd0, reg_idx_t'(i), 16'h1000 + 16'(i)));
        run_program();
    endtask

    task automatic branch_program();
        int        i;
        int        blk;
        int        s;
        int        skip;
        reg_idx_t  fr;
        reg_idx_t  x;
        reg_idx_t  y;
        mem_addr_t target;
        begin_test("flag_branch");
        for (i = 1; i < 8; i++)
            emit(encode(OP_ADDI, reg_idx_t'(i), 3'd0, 3'd0, small_imm(8)));
        for (blk = 0; blk < 12; blk++)
        begin
            fr = pick_reg(1, 7);
            x  = pick_reg(1, 7);
            y  = pick_reg(1, 7);
            case ($urandom % 3)
                0:       emit(encode(OP_CMPLT, fr, x, y, 16'd0));
                1:       emit(encode(OP_SUB, fr, x, y, 16'd0));   // Zero when equal
                default: emit(encode(OP_ADDI, fr, x, 3'd0, small_imm(6)));
            endcase
            emit(encode(OP_STORE, 3'd0, 3'd0, fr, 16'h1200 + 16'(blk)));
            skip   = 1 + int'($urandom % 3);
            target = mem_addr_t'(prog_len + 1 + 2 * skip);
            emit(encode(OP_BRF, 3'd0, fr, 3'd0, target));
            for (s = 0; s < skip; s++)
            begin
                x = pick_reg(1, 7);
                emit(encode(OP_ADDI, x, x, 3'd0, small_imm(6)));
                emit(encode(OP_STORE, 3'd0, 3'd0, x, 16'h1100 + 16'(prog_len)));
            end
            if (blk % 3 == 2)
            begin
                emit(encode(OP_JMP, 3'd0, 3'd0, 3'd0, mem_addr_t'(prog_len + 2)));
                emit(encode(OP_STORE, 3'd0, 3'd0, 3'd1, 16'h11ff));   // Jumped over
            end
        end
        run_program();
    endtask

    // Base register r7 and working registers r1..r6
    task automatic load_modify_store();
        int       k;
        reg_idx_t x;
        reg_idx_t y;
        begin_test("load_store");
        for (k = 0; k < 32; k++)
            mem[16'h2000 + k] = $urandom;
        emit(encode(OP_ADDI, 3'd7, 3'd0, 3'd0, 16'h2000));
        for (k = 0; k < 24; k++)
        begin
            x = pick_reg(1, 6);
            y = pick_reg(1, 6);
            emit(encode(OP_LOAD, x, 3'd7, 3'd0, 16'($urandom % 32)));
            emit(encode(random_alu_op(), x, x, y, small_imm(64)));
            emit(encode(OP_STORE, 3'd0, 3'd7, x, 16'($urandom % 32)));
        end
        run_program();
    endtask

    task automatic bus_contention();
        int k;
        begin_test("bus_sharing");
        for (k = 0; k < 16; k++)
            mem[16'h3000 + k] = $urandom;
        emit(encode(OP_ADDI, 3'd7, 3'd0, 3'd0, 16'h3000));
        for (k = 0; k < 40; k++)
        begin
            if ($urandom % 2 == 0)
                emit(encode(OP_LOAD, pick_reg(1, 6), 3'd7, 3'd0, 16'($urandom % 16)));
            else
                emit(encode(OP_STORE, 3'd0, 3'd7, pick_reg(1, 6), 16'($urandom % 16)));
        end
        run_program();
    endtask

    initial
    begin
        int seed_ret;
        rst          = 1'b1;
        mem_rdata    = '0;
        watch_on     = 1'b0;
        watch_start  = 0;
        watch_limit  = 0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        cur_name     = "startup";
        seed_ret     = $urandom(SEED);

        verify_reset_state();
        alu_mix_program();
        branch_program();
        load_modify_store();
        bus_contention();

        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- cpu.f
+incdir+bench
design/cpu_pkg.sv
design/reg_file.sv
design/alu.sv
design/fetch_unit.sv
design/mem_arbiter.sv
design/cpu_control.sv
design/cpu_top.sv
bench/cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the CPU testbench with Verilator, runs it and checks the log
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f cpu.f --top-module cpu_tb -o cpu_sim

./obj_dir/cpu_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failures"
